// File: verilog/eeprom_pkg.sv
package eeprom_pkg;

    localparam int ADDR_W = 11;

    // 24c16 device type, upper nibble of the control byte
    localparam logic [3:0] EEPROM_DEV_CODE = 4'b1010;

    typedef enum logic {
        OP_WRITE,
        OP_READ
    } eeprom_op_e;

    typedef enum logic [1:0] {
        CMD_START,  // also used for repeated start
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bus_cmd_e;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START_A,
        ST_START_B,
        ST_START_C,
        ST_STOP_A,
        ST_STOP_B,
        ST_STOP_C,
        ST_DATA,
        ST_ACK,
        ST_DONE
    } engine_state_e;

    typedef enum logic [3:0] {
        TS_IDLE,
        TS_START,
        TS_CTRL_W,
        TS_ADDR,
        TS_DATA_W,
        TS_RESTART,
        TS_CTRL_R,
        TS_DATA_R,
        TS_STOP,
        TS_WAIT_ACK,
        TS_FINISH
    } txn_state_e;

endpackage

// File: verilog/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine import eeprom_pkg::*; #(
    parameter int CLK_DIV = 4
) (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cmd_req,
    input  bus_cmd_e   cmd,
    input  logic [7:0] tx_byte,
    output logic       cmd_ack,
    output logic [7:0] rx_byte,
    output logic       nack,
    output logic       scl,
    output logic       sda_oe,
    input  logic       sda_in
);

    localparam int DIV_W = $clog2(CLK_DIV);

    engine_state_e    state;
    bus_cmd_e         cur_cmd;
    logic [DIV_W-1:0] div_cnt;
    logic [7:0]       shreg;
    logic [2:0]       bit_cnt;
    logic             half_hi;   // second half of a bit, scl high
    logic             sda_pend;  // sda_oe one cycle ahead
    logic             tick;
    logic             running;

    assign tick    = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign running = (state != ST_IDLE) && (state != ST_DONE);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= ST_IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            half_hi  <= 1'b0;
            scl      <= 1'b1;
            sda_pend <= 1'b0;
            sda_oe   <= 1'b0;
            cmd_ack  <= 1'b0;
            nack     <= 1'b0;
        end
        else
        begin
            // sda follows scl by one clock so data never moves on an scl edge
            sda_oe <= sda_pend;

            if (running)
                div_cnt <= tick ? '0 : div_cnt + 1'b1;

            case (state)
                ST_IDLE:
                    if (cmd_req)
                    begin
                        cur_cmd <= cmd;
                        shreg   <= tx_byte;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        half_hi <= 1'b0;
                        scl     <= 1'b0;
                        case (cmd)
                            CMD_START: state <= ST_START_A;
                            CMD_STOP:  state <= ST_STOP_A;
                            default:   state <= ST_DATA;
                        endcase
                        case (cmd)
                            CMD_STOP:  sda_pend <= 1'b1;
                            CMD_WRITE: sda_pend <= ~tx_byte[7];
                            default:   sda_pend <= 1'b0;
                        endcase
                    end
                ST_START_A:
                    if (tick)
                    begin
                        scl   <= 1'b1;
                        state <= ST_START_B;
                    end
                ST_START_B:
                    if (tick)
                    begin
                        sda_pend <= 1'b1;  // sda falls, scl high
                        state    <= ST_START_C;
                    end
                ST_STOP_A:
                    if (tick)
                    begin
                        scl   <= 1'b1;
                        state <= ST_STOP_B;
                    end
                ST_STOP_B:
                    if (tick)
                    begin
                        sda_pend <= 1'b0;  // sda rises, scl high
                        state    <= ST_STOP_C;
                    end
                ST_START_C, ST_STOP_C:
                    if (tick)
                    begin
                        cmd_ack <= 1'b1;
                        state   <= ST_DONE;
                    end
                ST_DATA:
                    if (tick)
                    begin
                        half_hi <= ~half_hi;
                        scl     <= ~half_hi;
                        if (half_hi)
                        begin
                            if (cur_cmd == CMD_READ)
                                rx_byte <= {rx_byte[6:0], sda_in};
                            shreg <= {shreg[6:0], 1'b0};
                            if (bit_cnt == 3'd7)
                            begin
                                sda_pend <= 1'b0;  // ninth bit, line released
                                state    <= ST_ACK;
                            end
                            else
                            begin
                                bit_cnt  <= bit_cnt + 1'b1;
                                sda_pend <= (cur_cmd == CMD_WRITE) & ~shreg[6];
                            end
                        end
                    end
                ST_ACK:
                    if (tick)
                    begin
                        half_hi <= ~half_hi;
                        if (!half_hi)
                            scl <= 1'b1;
                        else
                        begin
                            nack    <= (cur_cmd == CMD_WRITE) & sda_in;
                            cmd_ack <= 1'b1;
                            state   <= ST_DONE;
                        end
                    end
                ST_DONE:
                    if (!cmd_req)
                    begin
                        cmd_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/eeprom_txn_sequencer.sv
`timescale 1ns/1ps

module eeprom_txn_sequencer import eeprom_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              req,
    input  eeprom_op_e        op,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        wdata,
    output logic              ack,
    output logic [7:0]        rdata,
    output logic              err,
    output logic              cmd_req,
    output bus_cmd_e          cmd,
    output logic [7:0]        tx_byte,
    input  logic              cmd_ack,
    input  logic [7:0]        rx_byte,
    input  logic              nack
);

    txn_state_e        state;
    txn_state_e        step;       // command in flight
    txn_state_e        next_step;
    eeprom_op_e        op_q;
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        wdata_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= TS_IDLE;
            step      <= TS_IDLE;
            next_step <= TS_IDLE;
            ack       <= 1'b0;
            err       <= 1'b0;
            cmd_req   <= 1'b0;
        end
        else
        begin
            case (state)
                TS_IDLE:
                    if (req && !ack)
                    begin
                        op_q    <= op;
                        addr_q  <= addr;
                        wdata_q <= wdata;
                        err     <= 1'b0;
                        state   <= TS_START;
                    end
                TS_START, TS_RESTART:
                    begin
                        cmd     <= CMD_START;
                        cmd_req <= 1'b1;
                        step    <= state;
                        state   <= TS_WAIT_ACK;
                    end
                TS_CTRL_W, TS_CTRL_R:
                    begin
                        cmd     <= CMD_WRITE;
                        tx_byte <= {EEPROM_DEV_CODE, addr_q[10:8], state == TS_CTRL_R};
                        cmd_req <= 1'b1;
                        step    <= state;
                        state   <= TS_WAIT_ACK;
                    end
                TS_ADDR, TS_DATA_W:
                    begin
                        cmd     <= CMD_WRITE;
                        tx_byte <= (state == TS_ADDR) ? addr_q[7:0] : wdata_q;
                        cmd_req <= 1'b1;
                        step    <= state;
                        state   <= TS_WAIT_ACK;
                    end
                TS_DATA_R:
                    begin
                        cmd     <= CMD_READ;
                        cmd_req <= 1'b1;
                        step    <= state;
                        state   <= TS_WAIT_ACK;
                    end
                TS_STOP:
                    begin
                        cmd     <= CMD_STOP;
                        cmd_req <= 1'b1;
                        step    <= state;
                        state   <= TS_WAIT_ACK;
                    end
                TS_WAIT_ACK:
                    if (cmd_req && cmd_ack)
                    begin
                        cmd_req <= 1'b0;
                        if (cmd == CMD_WRITE && nack)
                        begin
                            err       <= 1'b1;  // no slave ack, abort
                            next_step <= TS_STOP;
                        end
                        else
                        begin
                            case (step)
                                TS_START:   next_step <= TS_CTRL_W;
                                TS_CTRL_W:  next_step <= TS_ADDR;
                                TS_ADDR:    next_step <= (op_q == OP_READ) ? TS_RESTART
                                                                           : TS_DATA_W;
                                TS_RESTART: next_step <= TS_CTRL_R;
                                TS_CTRL_R:  next_step <= TS_DATA_R;
                                TS_STOP:    next_step <= TS_FINISH;
                                default:    next_step <= TS_STOP;  // both data bytes
                            endcase
                        end
                        if (step == TS_DATA_R)
                            rdata <= rx_byte;
                    end
                    else if (!cmd_req && !cmd_ack)
                        state <= next_step;
                TS_FINISH:
                    if (!ack)
                        ack <= 1'b1;
                    else if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= TS_IDLE;
                    end
                default: state <= TS_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top import eeprom_pkg::*; #(
    parameter int CLK_DIV = 4  // clk cycles per scl half-period
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              req,
    input  eeprom_op_e        op,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        wdata,
    output logic              ack,
    output logic [7:0]        rdata,
    output logic              err,
    output logic              scl,
    output logic              sda_oe,
    input  logic              sda_in
);

    // sequencer to bit engine
    logic       cmd_req;
    bus_cmd_e   cmd;
    logic [7:0] tx_byte;
    logic       cmd_ack;
    logic [7:0] rx_byte;
    logic       nack;

    eeprom_txn_sequencer eeprom_txn_sequencer_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .req     (req),
        .op      (op),
        .addr    (addr),
        .wdata   (wdata),
        .ack     (ack),
        .rdata   (rdata),
        .err     (err),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .tx_byte (tx_byte),
        .cmd_ack (cmd_ack),
        .rx_byte (rx_byte),
        .nack    (nack)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) i2c_bit_engine_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .tx_byte (tx_byte),
        .cmd_ack (cmd_ack),
        .rx_byte (rx_byte),
        .nack    (nack),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda_in)
    );

endmodule

// File: tests/eeprom_slave_model.sv
`timescale 1ns/1ps

module eeprom_slave_model import eeprom_pkg::*; (
    input  logic scl,
    input  logic sda,
    input  logic absent,     // no device answers
    output logic sda_oe,
    output logic in_txn,     // between start and stop
    output logic violation
);

    typedef enum logic [1:0] {
        PH_CTRL,
        PH_ADDR,
        PH_DATA,
        PH_IGNORE
    } phase_e;

    logic [7:0]        mem [0:(1 << ADDR_W) - 1];
    logic [ADDR_W-1:0] ptr;
    logic [7:0]        shreg;
    logic [7:0]        tx_data;
    logic [3:0]        bit_cnt;
    logic              bit_val;
    logic              bit_valid;  // scl high phase that was not a start or stop
    logic              restarted;
    logic              got_addr;
    logic              start_tx;
    logic              tx_mode;
    phase_e            phase;

    initial
    begin
        for (int i = 0; i < (1 << ADDR_W); i++)
            mem[i] = 8'(i ^ (i >> 8));  // contents differ per address
        sda_oe    = 1'b0;
        in_txn    = 1'b0;
        violation = 1'b0;
        bit_valid = 1'b0;
        bit_cnt   = '0;
        got_addr  = 1'b0;
        start_tx  = 1'b0;
        tx_mode   = 1'b0;
    end

    task automatic flag_violation(input string what);
        $display("slave model at %0t: %s", $time, what);
        violation = 1'b1;
    endtask

    task automatic take_byte(input logic [7:0] b);
        sda_oe = 1'b0;
        case (phase)
            PH_CTRL:
                if (b[7:4] != EEPROM_DEV_CODE || absent)
                    phase = PH_IGNORE;
                else
                begin
                    sda_oe          = 1'b1;
                    ptr[ADDR_W-1:8] = b[3:1];  // block bits
                    if (b[0] && !(restarted && got_addr))
                        flag_violation("read control byte without a repeated start");
                    if (!b[0] && restarted)
                        flag_violation("repeated start not followed by a read control byte");
                    start_tx = b[0];
                    phase    = b[0] ? PH_IGNORE : PH_ADDR;
                end
            PH_ADDR:
            begin
                ptr[7:0] = b;
                got_addr = 1'b1;
                sda_oe   = 1'b1;
                phase    = PH_DATA;
            end
            PH_DATA:
            begin
                mem[ptr] = b;
                ptr      = ptr + 1'b1;
                sda_oe   = 1'b1;
            end
            default: ;
        endcase
    endtask

    // start, repeated start
    always @(negedge sda)
        if (scl === 1'b1)
        begin
            if (in_txn && bit_cnt != 0)
                flag_violation("start condition inside a byte");
            restarted = in_txn;
            in_txn    = 1'b1;
            bit_cnt   = '0;
            bit_valid = 1'b0;
            tx_mode   = 1'b0;
            start_tx  = 1'b0;
            sda_oe    = 1'b0;
            phase     = PH_CTRL;
        end

    always @(posedge sda)
        if (scl === 1'b1)
        begin
            if (!in_txn || bit_cnt != 0)
                flag_violation("stop condition outside a transaction or inside a byte");
            in_txn    = 1'b0;
            bit_valid = 1'b0;
            got_addr  = 1'b0;
            sda_oe    = 1'b0;
        end

    always @(posedge scl)
    begin
        bit_val   = sda;
        bit_valid = in_txn;
    end

    // bit is done at scl fall, slave output changes here
    always @(negedge scl)
        if (bit_valid)
        begin
            bit_valid = 1'b0;
            bit_cnt   = bit_cnt + 1'b1;
            shreg     = {shreg[6:0], bit_val};
            if (bit_cnt < 8)
                sda_oe = tx_mode & ~tx_data[7 - bit_cnt];
            else if (bit_cnt == 8)
            begin
                if (tx_mode)
                    sda_oe = 1'b0;  // ninth bit belongs to the master
                else
                    take_byte(shreg);
            end
            else
            begin
                if (tx_mode && !bit_val)
                    flag_violation("master acknowledged the read data byte");
                bit_cnt  = '0;
                tx_mode  = start_tx;
                start_tx = 1'b0;
                tx_data  = mem[ptr];
                sda_oe   = tx_mode & ~tx_data[7];
            end
        end

endmodule

// File: tests/eeprom_ctrl_tb.sv
`timescale 1ns/1ps

module eeprom_ctrl_tb import eeprom_pkg::*; ();

    localparam int MAX_CYCLES = 210 * 400;  // transactions times worst case length

    logic              CLK = 1'b0;
    logic              RESET;
    logic              req;
    eeprom_op_e        op;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic              ack;
    logic [7:0]        rdata;
    logic              err;
    logic              scl;
    logic              sda_oe;
    logic              slave_oe;
    logic              sda;
    logic              absent;
    logic              in_txn;
    logic              violation;
    logic              ack_q;
    logic [7:0]        ref_mem [0:(1 << ADDR_W) - 1];
    logic [31:0]       seed = 32'h317e8036;
    int                cycles = 0;

    // open drain, either side pulls low
    assign sda = (sda_oe === 1'b1 || slave_oe === 1'b1) ? 1'b0 : 1'b1;

    always #5 CLK = ~CLK;

    eeprom_ctrl_top eeprom_ctrl_top_i (
        .CLK    (CLK),
        .RESET  (RESET),
        .req    (req),
        .op     (op),
        .addr   (addr),
        .wdata  (wdata),
        .ack    (ack),
        .rdata  (rdata),
        .err    (err),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda)
    );

    eeprom_slave_model eeprom_slave_model_i (
        .scl       (scl),
        .sda       (sda),
        .absent    (absent),
        .sda_oe    (slave_oe),
        .in_txn    (in_txn),
        .violation (violation)
    );

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    always @(posedge violation)
    begin
        $display("the slave model saw a bus protocol violation");
        $display("=== FAIL ===");
        $fatal(1, "protocol violation");
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timed out after %0d cycles without finishing the tests", cycles);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    // ack may only rise on a pending request
    always @(posedge CLK)
    begin
        if (ack && !ack_q)
            check_value("req", req, 1'b1);
        ack_q <= ack;
    end

    task automatic run_txn(input eeprom_op_e t_op, input logic [ADDR_W-1:0] t_addr,
                           input logic [7:0] t_wdata, output logic [7:0] t_rdata,
                           output logic t_err);
        int hold;

        hold = next_rand() >> 30;  // 0 to 3 extra cycles of back-pressure
        @(posedge CLK);
        req   <= 1'b1;
        op    <= t_op;
        addr  <= t_addr;
        wdata <= t_wdata;
        do
            @(posedge CLK);
        while (ack !== 1'b1);
        t_rdata = rdata;
        t_err   = err;
        repeat (hold)
        begin
            @(posedge CLK);
            check_value("ack", ack, 1'b1);
            check_value("rdata", rdata, t_rdata);
            check_value("err", err, t_err);
        end
        req <= 1'b0;
        do
            @(posedge CLK);
        while (ack !== 1'b0);
        check_value("scl", scl, 1'b1);  // bus back to idle
        check_value("sda", sda, 1'b1);
        check_value("in_txn", in_txn, 1'b0);
    endtask

    task automatic write_and_expect(input logic [ADDR_W-1:0] a, input logic [7:0] d,
                                    input logic exp_err);
        logic [7:0] rd;
        logic       e;

        run_txn(OP_WRITE, a, d, rd, e);
        check_value("err", e, exp_err);
        if (!exp_err)
            ref_mem[a] = d;
    endtask

    task automatic read_and_expect(input logic [ADDR_W-1:0] a, input logic exp_err);
        logic [7:0] rd;
        logic       e;

        run_txn(OP_READ, a, 8'h00, rd, e);
        check_value("err", e, exp_err);
        if (!exp_err)
            check_value("rdata", rd, ref_mem[a]);
    endtask

    initial
    begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] last_wr;

        RESET  = 1'b1;
        req    = 1'b0;
        op     = OP_WRITE;
        addr   = '0;
        wdata  = '0;
        absent = 1'b0;
        for (int i = 0; i < (1 << ADDR_W); i++)
            ref_mem[i] = 8'(i ^ (i >> 8));  // same preset as the slave
        repeat (8) @(posedge CLK);
        RESET <= 1'b0;
        repeat (6)
        begin
            @(posedge CLK);
            check_value("scl", scl, 1'b1);
            check_value("sda_oe", sda_oe, 1'b0);
            check_value("ack", ack, 1'b0);
            check_value("err", err, 1'b0);
        end

        last_wr = 11'h5a3;
        write_and_expect(last_wr, 8'h3c, 1'b0);
        read_and_expect(last_wr, 1'b0);

        for (int n = 0; n < 200; n++)
        begin
            r = next_rand();
            a = r[30:20];
            if (r[31])
            begin
                if (r[11])
                    a = last_wr;  // revisit a written location
                read_and_expect(a, 1'b0);
            end
            else
            begin
                write_and_expect(a, r[19:12], 1'b0);
                last_wr = a;
            end
        end

        // device gone, memory must stay as it was
        absent <= 1'b1;
        write_and_expect(last_wr, ~ref_mem[last_wr], 1'b1);
        read_and_expect(last_wr, 1'b1);
        absent <= 1'b0;
        read_and_expect(last_wr, 1'b0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: verilog.f
verilog/eeprom_pkg.sv
verilog/i2c_bit_engine.sv
verilog/eeprom_txn_sequencer.sv
verilog/eeprom_ctrl_top.sv
tests/eeprom_slave_model.sv
tests/eeprom_ctrl_tb.sv

// File: Bender.yml
package:
  name: eeprom_ctrl

sources:
  - verilog/eeprom_pkg.sv
  - verilog/i2c_bit_engine.sv
  - verilog/eeprom_txn_sequencer.sv
  - verilog/eeprom_ctrl_top.sv
  - target: test
    files:
      - tests/eeprom_slave_model.sv
      - tests/eeprom_ctrl_tb.sv
